// ==== verilog/sdPkg.sv ====
package sdPkg;

    typedef logic [47:0] cmdFrame_t;     // Command, argument, CRC
    typedef logic [39:0] resp_t;         // R1 in low byte, R7 full width
    typedef logic [31:0] word_t;
    typedef logic [6:0]  wordAddr_t;
    typedef logic [5:0]  bitCount_t;

    localparam int BLOCK_WORDS = 128;

    localparam cmdFrame_t CMD0_FRAME   = {8'h40, 32'h0000_0000, 8'h95};
    localparam cmdFrame_t CMD8_FRAME   = {8'h48, 20'h00000, 4'b0001, 8'hAA, 8'h87};
    localparam cmdFrame_t CMD55_FRAME  = {8'h77, 32'h0000_0000, 8'h01};
    localparam cmdFrame_t ACMD41_FRAME = {8'h69, 32'h4000_0000, 8'h01};  // HCS set
    localparam cmdFrame_t CMD16_FRAME  = {8'h50, 32'h0000_0200, 8'h00};  // 512 byte blocks
    localparam cmdFrame_t CMD17_FRAME  = {8'h51, 32'h0000_0000, 8'h01};  // Block 0

    localparam logic [7:0] R1_IDLE     = 8'h01;
    localparam logic [7:0] R1_READY    = 8'h00;
    localparam logic [7:0] START_TOKEN = 8'hFE;

    localparam int RESP_TIMEOUT_HALF = 64;
    localparam int POWERUP_HALF      = 160;

    typedef enum logic [3:0] {
        SEQ_CMD0,
        SEQ_CMD8,
        SEQ_CMD55,
        SEQ_ACMD41,
        SEQ_CMD16,
        SEQ_CMD17,
        SEQ_TOKEN,      // Poll single bytes for the start token
        SEQ_WORD,
        SEQ_CRC,
        SEQ_READY,
        SEQ_ERROR
    } seqState_t;

endpackage

// ==== verilog/spiFrameIf.sv ====
`timescale 1ns/1ps

interface spiFrameIf;
    import sdPkg::*;

    logic      start;    // One cycle, only while idle
    cmdFrame_t frame;
    bitCount_t txBits;   // Zero skips preamble, send and wait
    bitCount_t rxBits;
    logic      idle;
    logic      done;
    logic      timeout;
    resp_t     rxData;   // Valid from done until next start

    modport seq (
        output start, frame, txBits, rxBits,
        input  idle, done, timeout, rxData
    );

    modport phy (
        input  start, frame, txBits, rxBits,
        output idle, done, timeout, rxData
    );

endinterface

// ==== verilog/spiShifter.sv ====
`timescale 1ns/1ps

module spiShifter #(
    parameter int clkDiv = 2
) (
    input  logic   clk,
    input  logic   rstN,
    spiFrameIf.phy bus,
    output logic   sdClk,
    output logic   sdMosi,
    input  logic   sdMiso,
    output logic   sdCs
);
    import sdPkg::*;

    typedef enum logic [2:0] {
        PH_POWERUP,
        PH_IDLE,
        PH_PRE,
        PH_SEND,
        PH_WAIT,
        PH_RECV
    } phase_t;

    phase_t    phase;
    logic [15:0] divCnt;
    logic        tick;
    logic [7:0]  halfCnt;   // Half clocks in power-up, preamble and wait
    bitCount_t   bitCnt;
    bitCount_t   rxCnt;
    cmdFrame_t   txShift;
    resp_t       rxShift;

    assign tick       = (divCnt == 16'(clkDiv - 1));
    assign bus.rxData = rxShift;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase       <= PH_POWERUP;
            divCnt      <= '0;
            halfCnt     <= '0;
            bitCnt      <= '0;
            rxCnt       <= '0;
            txShift     <= '0;
            rxShift     <= '0;
            sdClk       <= 1'b0;
            sdMosi      <= 1'b1;
            sdCs        <= 1'b1;
            bus.idle    <= 1'b0;
            bus.done    <= 1'b0;
            bus.timeout <= 1'b0;
        end else begin
            bus.done    <= 1'b0;
            bus.timeout <= 1'b0;
            if (phase == PH_IDLE) begin
                divCnt <= '0;   // Align half periods to the request
                if (bus.start) begin
                    bus.idle <= 1'b0;
                    txShift  <= bus.frame;
                    bitCnt   <= bus.txBits;
                    rxCnt    <= bus.rxBits;
                    halfCnt  <= '0;
                    if (bus.txBits != '0) begin
                        phase <= PH_PRE;
                        sdCs  <= 1'b1;
                    end else begin
                        phase <= PH_RECV;   // Data phase, CS held low
                    end
                end
            end else if (!tick) begin
                divCnt <= divCnt + 16'd1;
            end else begin
                divCnt <= '0;
                case (phase)
                    PH_POWERUP: begin
                        sdClk   <= ~sdClk;
                        halfCnt <= halfCnt + 8'd1;
                        if (halfCnt == 8'(POWERUP_HALF - 1)) begin
                            phase    <= PH_IDLE;
                            halfCnt  <= '0;
                            bus.idle <= 1'b1;
                        end
                    end
                    PH_PRE: begin
                        sdClk   <= ~sdClk;
                        sdMosi  <= 1'b1;
                        halfCnt <= halfCnt + 8'd1;
                        if (halfCnt == 8'd15) begin
                            sdCs    <= 1'b0;
                            sdMosi  <= txShift[47];   // First bit before first rise
                            txShift <= {txShift[46:0], 1'b0};
                            phase   <= PH_SEND;
                        end
                    end
                    PH_SEND: begin
                        if (!sdClk) begin
                            sdClk <= 1'b1;
                        end else begin
                            sdClk  <= 1'b0;
                            bitCnt <= bitCnt - 6'd1;
                            if (bitCnt == 6'd1) begin
                                sdMosi  <= 1'b1;
                                halfCnt <= '0;
                                phase   <= PH_WAIT;
                            end else begin
                                sdMosi  <= txShift[47];
                                txShift <= {txShift[46:0], 1'b0};
                            end
                        end
                    end
                    PH_WAIT: begin
                        if (!sdClk && !sdMiso) begin
                            phase <= PH_RECV;   // Start bit is the response MSB
                        end else if (halfCnt == 8'(RESP_TIMEOUT_HALF - 1)) begin
                            sdClk       <= 1'b0;
                            bus.timeout <= 1'b1;
                            bus.idle    <= 1'b1;
                            phase       <= PH_IDLE;
                        end else begin
                            sdClk   <= ~sdClk;
                            halfCnt <= halfCnt + 8'd1;
                        end
                    end
                    PH_RECV: begin
                        if (!sdClk) begin
                            sdClk   <= 1'b1;
                            rxShift <= {rxShift[38:0], sdMiso};   // Sample on rise
                            rxCnt   <= rxCnt - 6'd1;
                        end else begin
                            sdClk <= 1'b0;
                            if (rxCnt == '0) begin
                                bus.done <= 1'b1;
                                bus.idle <= 1'b1;
                                phase    <= PH_IDLE;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== verilog/sdCmdSequencer.sv ====
`timescale 1ns/1ps

module sdCmdSequencer (
    input  logic             clk,
    input  logic             rstN,
    spiFrameIf.seq           bus,
    output logic             wrEn,
    output sdPkg::wordAddr_t wrAddr,
    output sdPkg::word_t     wrData,
    output logic             ready,
    output logic             error
);
    import sdPkg::*;

    seqState_t  state;
    logic       pending;   // Request issued, waiting for done or timeout
    wordAddr_t  wordIdx;
    logic [7:0] r1;

    assign r1    = bus.rxData[7:0];
    assign ready = (state == SEQ_READY);
    assign error = (state == SEQ_ERROR);

    always_comb begin
        bus.frame  = CMD0_FRAME;
        bus.txBits = bitCount_t'(48);
        bus.rxBits = bitCount_t'(8);
        case (state)
            SEQ_CMD8: begin
                bus.frame  = CMD8_FRAME;
                bus.rxBits = bitCount_t'(40);   // R7
            end
            SEQ_CMD55:  bus.frame = CMD55_FRAME;
            SEQ_ACMD41: bus.frame = ACMD41_FRAME;
            SEQ_CMD16:  bus.frame = CMD16_FRAME;
            SEQ_CMD17:  bus.frame = CMD17_FRAME;
            SEQ_TOKEN: begin
                bus.txBits = '0;
            end
            SEQ_WORD: begin
                bus.txBits = '0;
                bus.rxBits = bitCount_t'(32);
            end
            SEQ_CRC: begin
                bus.txBits = '0;
                bus.rxBits = bitCount_t'(16);   // CRC dropped
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= SEQ_CMD0;
            pending   <= 1'b0;
            bus.start <= 1'b0;
            wordIdx   <= '0;
            wrEn      <= 1'b0;
        end else begin
            bus.start <= 1'b0;
            wrEn      <= 1'b0;
            if (pending) begin
                if (bus.timeout) begin
                    pending <= 1'b0;
                    state   <= SEQ_ERROR;
                end else if (bus.done) begin
                    pending <= 1'b0;
                    case (state)
                        SEQ_CMD0: begin
                            if (r1 == R1_IDLE)
                                state <= SEQ_CMD8;   // Otherwise retry CMD0
                        end
                        SEQ_CMD8: begin
                            state <= (bus.rxData[39:32] == R1_IDLE) ? SEQ_CMD55 : SEQ_ERROR;
                        end
                        SEQ_CMD55: begin
                            if (r1 == R1_IDLE || r1 == R1_READY)
                                state <= SEQ_ACMD41;
                            else
                                state <= SEQ_ERROR;
                        end
                        SEQ_ACMD41: begin
                            if (r1 == R1_IDLE)
                                state <= SEQ_CMD55;   // Card still initializing
                            else if (r1 == R1_READY)
                                state <= SEQ_CMD16;
                            else
                                state <= SEQ_ERROR;
                        end
                        SEQ_CMD16: state <= (r1 == R1_READY) ? SEQ_CMD17 : SEQ_ERROR;
                        SEQ_CMD17: state <= (r1 == R1_READY) ? SEQ_TOKEN : SEQ_ERROR;
                        SEQ_TOKEN: begin
                            if (r1 == START_TOKEN) begin
                                state   <= SEQ_WORD;
                                wordIdx <= '0;
                            end
                        end
                        SEQ_WORD: begin
                            wrEn <= 1'b1;
                            if (wordIdx == wordAddr_t'(BLOCK_WORDS - 1))
                                state <= SEQ_CRC;
                            else
                                wordIdx <= wordIdx + 7'd1;
                        end
                        SEQ_CRC: state <= SEQ_READY;
                        default: ;
                    endcase
                end
            end else if (bus.idle && state != SEQ_READY && state != SEQ_ERROR) begin
                bus.start <= 1'b1;
                pending   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pending && bus.done && state == SEQ_WORD) begin
            wrAddr <= wordIdx;
            wrData <= bus.rxData[31:0];
        end
    end

endmodule

// ==== verilog/blockBuffer.sv ====
`timescale 1ns/1ps

module blockBuffer (
    input  logic             clk,
    input  logic             wrEn,
    input  sdPkg::wordAddr_t wrAddr,
    input  sdPkg::word_t     wrData,
    input  sdPkg::wordAddr_t rdAddr,
    output sdPkg::word_t     rdData
);
    import sdPkg::*;

    word_t mem [BLOCK_WORDS];   // One 512 byte block

    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrAddr] <= wrData;
    end

    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];   // One clk read latency
    end

endmodule

// ==== verilog/uartDump.sv ====
`timescale 1ns/1ps

module uartDump #(
    parameter int bitCycles = 8,
    parameter int dumpWords = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             dump,
    input  logic             ready,
    output sdPkg::wordAddr_t rdAddr,
    input  sdPkg::word_t     rdData,
    output logic             uartTx
);
    import sdPkg::*;

    logic        active;
    logic [15:0] timer;
    logic [3:0]  bitIdx;    // 0 start, 1 to 8 data, 9 stop
    logic [1:0]  byteIdx;   // 0 is the most significant byte
    wordAddr_t   wordIdx;
    logic [7:0]  curByte;
    logic [2:0]  dataIdx;
    logic        txBit;

    assign rdAddr  = wordIdx;
    assign curByte = rdData[{~byteIdx, 3'b000} +: 8];
    assign dataIdx = 3'(bitIdx - 4'd1);

    always_comb begin
        if (bitIdx == 4'd0)
            txBit = 1'b0;
        else if (bitIdx == 4'd9)
            txBit = 1'b1;
        else
            txBit = curByte[dataIdx];   // LSB first
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active  <= 1'b0;
            timer   <= '0;
            bitIdx  <= '0;
            byteIdx <= '0;
            wordIdx <= '0;
            uartTx  <= 1'b1;
        end else if (!active) begin
            uartTx <= 1'b1;
            if (dump && ready) begin
                active  <= 1'b1;
                timer   <= '0;
                bitIdx  <= '0;
                byteIdx <= '0;
                wordIdx <= '0;
            end
        end else begin
            uartTx <= txBit;
            if (timer == 16'(bitCycles - 1)) begin
                timer <= '0;
                if (bitIdx == 4'd9) begin
                    bitIdx <= '0;
                    if (byteIdx == 2'd3) begin
                        byteIdx <= '0;
                        if (wordIdx == wordAddr_t'(dumpWords - 1))
                            active <= 1'b0;
                        else
                            wordIdx <= wordIdx + 7'd1;   // Next word read ahead of data bits
                    end else begin
                        byteIdx <= byteIdx + 2'd1;
                    end
                end else begin
                    bitIdx <= bitIdx + 4'd1;
                end
            end else begin
                timer <= timer + 16'd1;
            end
        end
    end

endmodule

// ==== verilog/sdReader.sv ====
`timescale 1ns/1ps

module sdReader #(
    parameter int clkDiv    = 2,
    parameter int bitCycles = 8,
    parameter int dumpWords = 4
) (
    input  logic clk,
    input  logic rstN,
    output logic sdClk,
    output logic sdMosi,
    input  logic sdMiso,
    output logic sdCs,
    input  logic dump,
    output logic uartTx,
    output logic ready,
    output logic error
);
    import sdPkg::*;

    logic      wrEn;
    wordAddr_t wrAddr;
    word_t     wrData;
    wordAddr_t rdAddr;
    word_t     rdData;

    spiFrameIf frameBus ();

    spiShifter #(.clkDiv(clkDiv)) uShifter (
        .clk    (clk),
        .rstN   (rstN),
        .bus    (frameBus.phy),
        .sdClk  (sdClk),
        .sdMosi (sdMosi),
        .sdMiso (sdMiso),
        .sdCs   (sdCs)
    );

    sdCmdSequencer uSequencer (
        .clk    (clk),
        .rstN   (rstN),
        .bus    (frameBus.seq),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .ready  (ready),
        .error  (error)
    );

    blockBuffer uBuffer (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    uartDump #(.bitCycles(bitCycles), .dumpWords(dumpWords)) uDump (
        .clk    (clk),
        .rstN   (rstN),
        .dump   (dump),
        .ready  (ready),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .uartTx (uartTx)
    );

endmodule

// ==== test/sdCardModel.sv ====
`timescale 1ns/1ps

module sdCardModel (
    input  logic rstN,
    input  logic sdClk,
    input  logic sdCs,
    input  logic sdMosi,
    output logic sdMiso,
    input  logic dropCmd8,     // Stay silent on CMD8
    output logic orderFault,
    output int   cmdCount
);
    logic [7:0]  expCmd [10];
    logic [31:0] expArg [10];
    logic [31:0] block [128];
    logic [47:0] rxFrame;
    int          rxCount;      // 0 while hunting for a start bit
    int          acmdCount;
    bit          txQueue [$];

    function automatic logic [31:0] stepXorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic queueByte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--)
            txQueue.push_back(b[i]);
    endtask

    initial begin
        logic [31:0] x;
        expCmd = '{8'h40, 8'h48, 8'h77, 8'h69, 8'h77, 8'h69, 8'h77, 8'h69, 8'h50, 8'h51};
        expArg = '{32'h0, 32'h1AA, 32'h0, 32'h4000_0000, 32'h0, 32'h4000_0000,
                   32'h0, 32'h4000_0000, 32'h200, 32'h0};
        x = 32'd35663;
        for (int i = 0; i < 128; i++) begin
            x = stepXorshift(x);
            block[i] = x;
        end
        orderFault = 1'b0;
    end

    task automatic answerFrame(input logic [7:0] cmd, input logic [31:0] arg);
        logic ok;
        ok = (cmdCount < 10) ? (cmd == expCmd[cmdCount] && arg == expArg[cmdCount]) : 1'b0;
        assert (ok) else begin
            if (cmdCount < 10)
                $display("Error command order step %0d: expected %h %h, actual %h %h",
                         cmdCount, expCmd[cmdCount], expArg[cmdCount], cmd, arg);
            else
                $display("Card model got command %h with argument %h after the last step",
                         cmd, arg);
            orderFault = 1'b1;
        end
        cmdCount++;
        queueByte(8'hFF);   // One byte of response delay
        case (cmd)
            8'h40: queueByte(8'h01);
            8'h48: begin
                if (dropCmd8) begin
                    txQueue.delete();
                end else begin
                    queueByte(8'h01);
                    queueByte(8'h00);
                    queueByte(8'h00);
                    queueByte(8'h01);
                    queueByte(8'hAA);
                end
            end
            8'h77: queueByte(8'h01);
            8'h69: begin
                queueByte((acmdCount < 2) ? 8'h01 : 8'h00);   // Idle twice, then ready
                acmdCount++;
            end
            8'h50: queueByte(8'h00);
            8'h51: begin
                queueByte(8'h00);
                queueByte(8'hFF);
                queueByte(8'hFF);
                queueByte(8'hFE);
                for (int i = 0; i < 128; i++)
                    for (int k = 3; k >= 0; k--)
                        queueByte(block[i][8*k +: 8]);
                queueByte(8'h12);   // CRC
                queueByte(8'h34);
            end
            default: queueByte(8'h04);   // Illegal command
        endcase
    endtask

    always @(posedge sdClk or negedge rstN) begin
        if (!rstN) begin
            rxCount    = 0;
            cmdCount   = 0;
            acmdCount  = 0;
            orderFault = 1'b0;
            txQueue.delete();
        end else if (!sdCs) begin
            if (rxCount == 0) begin
                if (!sdMosi && txQueue.size() == 0) begin
                    rxFrame = '0;
                    rxCount = 1;
                end
            end else begin
                rxFrame = {rxFrame[46:0], sdMosi};
                rxCount++;
                if (rxCount == 48) begin
                    rxCount = 0;
                    answerFrame(rxFrame[47:40], rxFrame[39:8]);
                end
            end
        end
    end

    // MISO shifts on the falling edge
    always @(negedge sdClk or negedge rstN) begin
        if (!rstN)
            sdMiso <= 1'b1;
        else if (!sdCs && txQueue.size() > 0)
            sdMiso <= txQueue.pop_front();
        else
            sdMiso <= 1'b1;
    end

endmodule

// ==== test/sdReader_props.sv ====
`timescale 1ns/1ps

module sdReaderProps (
    input logic clk,
    input logic rstN,
    input logic sdClk,
    input logic sdMosi,
    input logic sdCs,
    input logic uartTx,
    input logic ready,
    input logic error
);

    // Outputs idle right after reset
    resetIdle: assert property (@(posedge clk)
        $rose(rstN) |-> (sdCs && uartTx && !sdClk && !ready && !error))
        else $error("outputs not idle after reset");

    mosiHighWhileDeselected: assert property (@(posedge clk) sdCs |-> sdMosi)
        else $error("sdMosi low while sdCs high");

    notReadyAndError: assert property (@(posedge clk) disable iff (!rstN)
        !(ready && error))
        else $error("ready and error both high");

    readySticky: assert property (@(posedge clk) disable iff (!rstN) ready |=> ready)
        else $error("ready dropped before reset");

    errorSticky: assert property (@(posedge clk) disable iff (!rstN) error |=> error)
        else $error("error dropped before reset");

endmodule

bind sdReader sdReaderProps props (
    .clk    (clk),
    .rstN   (rstN),
    .sdClk  (sdClk),
    .sdMosi (sdMosi),
    .sdCs   (sdCs),
    .uartTx (uartTx),
    .ready  (ready),
    .error  (error)
);

// ==== test/tbSdReader.sv ====
`timescale 1ns/1ps

module tbSdReader;
    localparam int BIT_CYCLES = 8;
    localparam int DUMP_WORDS = 4;
    localparam int WAIT_LIMIT = 200000;   // clk cycles

    logic        clk;
    logic        rstN;
    logic        sdClk;
    logic        sdMosi;
    logic        sdMiso;
    logic        sdCs;
    logic        dump;
    logic        uartTx;
    logic        ready;
    logic        error;
    logic        dropCmd8;
    logic        orderFault;
    int          cmdCount;
    logic [31:0] expWords [DUMP_WORDS];

    sdReader #(.clkDiv(2), .bitCycles(BIT_CYCLES), .dumpWords(DUMP_WORDS)) DUT (
        .clk(clk), .rstN(rstN), .sdClk(sdClk), .sdMosi(sdMosi), .sdMiso(sdMiso),
        .sdCs(sdCs), .dump(dump), .uartTx(uartTx), .ready(ready), .error(error)
    );

    sdCardModel card (
        .rstN(rstN), .sdClk(sdClk), .sdCs(sdCs), .sdMosi(sdMosi), .sdMiso(sdMiso),
        .dropCmd8(dropCmd8), .orderFault(orderFault), .cmdCount(cmdCount)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stopWithFailure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error %s: expected %h, actual %h", testName, exp, act);
            stopWithFailure();
        end
    endtask

    always @(posedge clk) begin
        if (orderFault) begin
            $display("Card model saw a command out of order");
            stopWithFailure();
        end
    end

    task automatic applyReset();
        rstN = 1'b0;
        dump = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("reset sdCs", 32'(1), 32'(sdCs));
        checkValue("reset uartTx", 32'(1), 32'(uartTx));
        checkValue("reset ready", 32'(0), 32'(ready));
        checkValue("reset error", 32'(0), 32'(error));
    endtask

    task automatic waitReadyOrError(input string testName);
        int n;
        n = 0;
        while (!ready && !error) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timed out in %s waiting for ready or error", testName);
                stopWithFailure();
            end
        end
    endtask

    task automatic pulseDump();
        dump = 1'b1;
        @(negedge clk);
        dump = 1'b0;
    endtask

    task automatic receiveByte(input string testName, output logic [7:0] b);
        int n;
        n = 0;
        while (uartTx) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timed out in %s waiting for a UART start bit", testName);
                stopWithFailure();
            end
        end
        repeat (BIT_CYCLES / 2) @(negedge clk);   // Middle of start bit
        checkValue({testName, " start bit"}, 32'(0), 32'(uartTx));
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            b[i] = uartTx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        checkValue({testName, " stop bit"}, 32'(1), 32'(uartTx));
    endtask

    task automatic receiveDump(input string testName, input bit busyPulse);
        logic [7:0] got;
        for (int w = 0; w < DUMP_WORDS; w++) begin
            for (int k = 0; k < 4; k++) begin
                receiveByte(testName, got);
                checkValue(testName, 32'(expWords[w][8*(3-k) +: 8]), 32'(got));
                if (busyPulse && w == 1 && k == 0)
                    pulseDump();   // Transmitter busy, must be dropped
            end
        end
    endtask

    task automatic checkLineIdle(input string testName);
        for (int n = 0; n < 30 * BIT_CYCLES; n++) begin
            @(negedge clk);
            assert (uartTx) else begin
                $display("UART line went active after %s without a dump", testName);
                stopWithFailure();
            end
        end
    endtask

    initial begin
        logic [31:0] x;
        rstN     = 1'b0;
        dump     = 1'b0;
        dropCmd8 = 1'b0;
        x = 32'd35663;
        for (int i = 0; i < DUMP_WORDS; i++) begin
            x = nextRandom(x);
            expWords[i] = x;
        end

        applyReset();
        waitReadyOrError("block read");
        checkValue("block read ready", 32'(1), 32'(ready));
        checkValue("block read error", 32'(0), 32'(error));
        checkValue("command count", 32'(10), 32'(cmdCount));

        pulseDump();
        receiveDump("dump", 1'b1);
        checkLineIdle("busy dump");
        pulseDump();
        receiveDump("second dump", 1'b0);
        checkLineIdle("second dump");

        dropCmd8 = 1'b1;
        applyReset();
        waitReadyOrError("timeout");
        checkValue("timeout error", 32'(1), 32'(error));
        checkValue("timeout ready", 32'(0), 32'(ready));
        checkValue("timeout command count", 32'(2), 32'(cmdCount));
        repeat (500) @(negedge clk);
        checkValue("timeout ready later", 32'(0), 32'(ready));

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/sdPkg.sv
verilog/spiFrameIf.sv
verilog/spiShifter.sv
verilog/sdCmdSequencer.sv
verilog/blockBuffer.sv
verilog/uartDump.sv
verilog/sdReader.sv
test/sdCardModel.sv
test/sdReader_props.sv
test/tbSdReader.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbSdReader -f vlog.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "All tests passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
